// ==== tb.f ====
+incdir+.
padframe_pkg.sv
padframe_regs.sv
padframe_out_mux.sv
padframe_in_demux.sv
padframe_top.sv
tb_padframe.sv

// ==== Bender.yml ====
package:
  name: padframe

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - padframe_pkg.sv
      - padframe_regs.sv
      - padframe_out_mux.sv
      - padframe_in_demux.sv
      - padframe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_padframe.sv

// ==== tb_padframe.sv ====
// Directed testbench for 8 pads, expects the register bus to answer in the request cycle
`include "padframe_cfg.svh"

module tb_padframe;

  import padframe_pkg::*;

  localparam int clk_period     = 40;
  localparam int timeout_cycles = 3000;

  logic           clk_i;
  logic           rst_n_i;
  reg_req_t       reg_req;
  reg_rsp_t       reg_rsp;
  pad_vec_t       gpio_out;
  pad_vec_t       gpio_dir;
  pad_vec_t       gpio_in;
  periph_to_pad_t periph_tx;
  pad_to_periph_t periph_rx;
  pad_vec_t       pad_in;
  pad_vec_t       pad_out;
  pad_vec_t       pad_oe;

  int          errors;
  int          checks;
  int          test_start_errors;
  logic [31:0] rng;
  // Expected register contents
  pad_cfg_t    cfg_exp [`PADFRAME_NUM_PADS];

  padframe_top padframe_top_i (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .reg_req_i  ( reg_req   ),
    .reg_rsp_o  ( reg_rsp   ),
    .gpio_out_i ( gpio_out  ),
    .gpio_dir_i ( gpio_dir  ),
    .gpio_in_o  ( gpio_in   ),
    .periph_i   ( periph_tx ),
    .periph_o   ( periph_rx ),
    .pad_in_i   ( pad_in    ),
    .pad_out_o  ( pad_out   ),
    .pad_oe_o   ( pad_oe    )
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t: %s, got 0x%0h expected 0x%0h", $time, msg, actual, expected);
    end
  endtask

  // Inputs change a short while after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data, output logic err);
    next_cycle();
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    #5;
    check_eq(reg_rsp.ready, 1'b1, "ready in write cycle");
    err = reg_rsp.error;
    if (addr < `PADFRAME_NUM_PADS * `PADFRAME_REG_STEP) begin
      cfg_exp[addr / `PADFRAME_REG_STEP] = pad_cfg_t'(data[3:0]);
    end
    next_cycle();
    reg_req = '0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data, output logic err);
    next_cycle();
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    #5;
    check_eq(reg_rsp.ready, 1'b1, "ready in read cycle");
    data = reg_rsp.rdata;
    err  = reg_rsp.error;
    next_cycle();
    reg_req = '0;
  endtask

  task automatic set_pad(input int p, input pad_func_t f, input pad_role_t r);
    logic err;
    reg_write(p * `PADFRAME_REG_STEP, {28'b0, r, f}, err);
    check_eq(err, 1'b0, "error on in-range write");
  endtask

  // Returns {out, oe} of one pad
  function automatic logic [1:0] pad_drive(input pad_cfg_t c, input logic gout,
                                           input logic gdir, input periph_to_pad_t pr);
    case (c.func)
      `PADFRAME_FUNC_GPIO: return {gout, gdir};
      `PADFRAME_FUNC_UART: return (c.role == `PADFRAME_ROLE_UART_TX) ? {pr.uart_tx, 1'b1} : 2'b00;
      `PADFRAME_FUNC_SPI: begin
        if (c.role == `PADFRAME_ROLE_SPI_SCK) return {pr.spi_sck, 1'b1};
        if (c.role == `PADFRAME_ROLE_SPI_CSN) return {pr.spi_csn, 1'b1};
        if (c.role == `PADFRAME_ROLE_SPI_MOSI) return {pr.spi_mosi, 1'b1};
        return 2'b00;
      end
      default: begin
        if (c.role == `PADFRAME_ROLE_I2C_SDA) return {pr.i2c_sda_o, pr.i2c_sda_oe};
        if (c.role == `PADFRAME_ROLE_I2C_SCL) return {pr.i2c_scl_o, pr.i2c_scl_oe};
        return 2'b00;
      end
    endcase
  endfunction

  task automatic check_pads(input string msg);
    pad_vec_t   exp_out;
    pad_vec_t   exp_oe;
    logic [1:0] d;
    #5;
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      d          = pad_drive(cfg_exp[p], gpio_out[p], gpio_dir[p], periph_tx);
      exp_out[p] = d[1];
      exp_oe[p]  = d[0];
    end
    check_eq(pad_out, exp_out, {msg, ", pad_out"});
    check_eq(pad_oe, exp_oe, {msg, ", pad_oe"});
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic test_reset_defaults();
    reg_data_t data;
    logic      err;
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      reg_read(p * `PADFRAME_REG_STEP, data, err);
      check_eq(data, 32'h0, "register after reset");
      check_eq(err, 1'b0, "error on in-range read");
    end
    repeat (4) begin
      next_cycle();
      rng      = xorshift(rng);
      gpio_out = rng[7:0];
      gpio_dir = rng[15:8];
      pad_in   = rng[23:16];
      check_pads("gpio after reset");
      check_eq(gpio_in, pad_in, "gpio_in follows pad_in");
      // Bus is idle here
      check_eq(reg_rsp.ready, 1'b0, "ready without request");
      check_eq(reg_rsp.error, 1'b0, "error without request");
    end
    end_test("reset_defaults");
  endtask

  task automatic test_reg_access();
    reg_data_t data;
    reg_data_t wdata;
    logic      err;
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      rng   = xorshift(rng);
      wdata = rng;
      reg_write(p * `PADFRAME_REG_STEP, wdata, err);
      check_eq(err, 1'b0, "error on in-range write");
      // Address bits 1:0 are ignored
      reg_read(p * `PADFRAME_REG_STEP + 3, data, err);
      check_eq(data, {28'b0, wdata[3:0]}, "read back after write");
    end
    reg_write(`PADFRAME_NUM_PADS * `PADFRAME_REG_STEP, 32'hf, err);
    check_eq(err, 1'b1, "error on write past last register");
    reg_write(32'h1000, 32'ha, err);
    check_eq(err, 1'b1, "error on far write");
    reg_read(`PADFRAME_NUM_PADS * `PADFRAME_REG_STEP, data, err);
    check_eq(err, 1'b1, "error on read past last register");
    check_eq(data, 32'h0, "rdata on out-of-range read");
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      reg_read(p * `PADFRAME_REG_STEP, data, err);
      check_eq(data, {28'b0, cfg_exp[p]}, "register after out-of-range writes");
      set_pad(p, `PADFRAME_FUNC_GPIO, 2'd0);
    end
    end_test("reg_access");
  endtask

  task automatic test_output_roles();
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      rng       = xorshift(rng);
      periph_tx = rng[7:0];
      gpio_out  = rng[15:8];
      gpio_dir  = rng[23:16];
      for (int f = 0; f < 4; f++) begin
        for (int r = 0; r < 4; r++) begin
          set_pad(p, f[1:0], r[1:0]);
          check_pads($sformatf("pad %0d func %0d role %0d", p, f, r));
        end
      end
      set_pad(p, `PADFRAME_FUNC_GPIO, 2'd0);
    end
    end_test("output_roles");
  endtask

  task automatic test_idle_roles();
    next_cycle();
    periph_tx = '1;
    gpio_out  = '1;
    gpio_dir  = '1;
    set_pad(0, `PADFRAME_FUNC_UART, 2'd2);
    set_pad(1, `PADFRAME_FUNC_UART, 2'd3);
    set_pad(2, `PADFRAME_FUNC_UART, `PADFRAME_ROLE_UART_RX);
    set_pad(3, `PADFRAME_FUNC_SPI, `PADFRAME_ROLE_SPI_MISO);
    set_pad(4, `PADFRAME_FUNC_I2C, 2'd2);
    set_pad(5, `PADFRAME_FUNC_I2C, 2'd3);
    set_pad(7, `PADFRAME_FUNC_UART, `PADFRAME_ROLE_UART_TX);
    #5;
    // Only pad 6 (GPIO) and pad 7 (UART TX) drive
    check_eq(pad_out, 8'hc0, "pad_out with idle roles");
    check_eq(pad_oe, 8'hc0, "pad_oe with idle roles");
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      set_pad(p, `PADFRAME_FUNC_GPIO, 2'd0);
    end
    end_test("idle_roles");
  endtask

  task automatic test_input_routing();
    pad_func_t  funcs [4];
    pad_role_t  roles [4];
    logic [3:0] exp;
    int         lo;
    int         hi;
    funcs[0] = `PADFRAME_FUNC_UART;
    roles[0] = `PADFRAME_ROLE_UART_RX;
    funcs[1] = `PADFRAME_FUNC_SPI;
    roles[1] = `PADFRAME_ROLE_SPI_MISO;
    funcs[2] = `PADFRAME_FUNC_I2C;
    roles[2] = `PADFRAME_ROLE_I2C_SDA;
    funcs[3] = `PADFRAME_FUNC_I2C;
    roles[3] = `PADFRAME_ROLE_I2C_SCL;
    next_cycle();
    rng    = xorshift(rng);
    pad_in = rng[7:0];
    #5;
    check_eq(periph_rx, 4'hf, "unassigned inputs idle high");
    for (int k = 0; k < 4; k++) begin
      lo = k;
      hi = k + 4;
      set_pad(hi, funcs[k], roles[k]);
      set_pad(lo, funcs[k], roles[k]);
      pad_in     = '0;
      pad_in[hi] = 1'b1;
      #5;
      // Field order in the struct puts uart_rx at bit 3
      exp        = 4'hf;
      exp[3 - k] = 1'b0;
      check_eq(periph_rx, exp, $sformatf("input %0d from lower pad", k));
      next_cycle();
      pad_in[lo] = 1'b1;
      pad_in[hi] = 1'b0;
      #5;
      exp[3 - k] = 1'b1;
      check_eq(periph_rx, exp, $sformatf("input %0d ignores higher pad", k));
      check_eq(gpio_in, pad_in, "gpio_in follows pad_in");
      set_pad(lo, `PADFRAME_FUNC_GPIO, 2'd0);
      #5;
      exp[3 - k] = 1'b0;
      check_eq(periph_rx, exp, $sformatf("input %0d from higher pad", k));
      set_pad(hi, `PADFRAME_FUNC_GPIO, 2'd0);
    end
    end_test("input_routing");
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    reg_req           = '0;
    gpio_out          = '0;
    gpio_dir          = '0;
    periph_tx         = '0;
    pad_in            = '0;
    errors            = 0;
    checks            = 0;
    test_start_errors = 0;
    rng               = 32'h549a;
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      cfg_exp[p] = '0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset_defaults();
    test_reg_access();
    test_output_roles();
    test_idle_roles();
    test_input_routing();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Tests need a few hundred cycles, so this leaves a wide margin
  initial begin
    #(clk_period * timeout_cycles);
    $display("Timeout: the tests did not finish within %0d clock periods", timeout_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== padframe_top.sv ====
// Pads are split into in, out and enable, config writes show on the pads right after the edge
module padframe_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  padframe_pkg::reg_req_t       reg_req_i,
  output padframe_pkg::reg_rsp_t       reg_rsp_o,
  input  padframe_pkg::pad_vec_t       gpio_out_i,
  input  padframe_pkg::pad_vec_t       gpio_dir_i,
  output padframe_pkg::pad_vec_t       gpio_in_o,
  input  padframe_pkg::periph_to_pad_t periph_i,
  output padframe_pkg::pad_to_periph_t periph_o,
  input  padframe_pkg::pad_vec_t       pad_in_i,
  output padframe_pkg::pad_vec_t       pad_out_o,
  output padframe_pkg::pad_vec_t       pad_oe_o
);

  import padframe_pkg::*;

  pad_cfg_array_t pad_cfg;

  padframe_regs padframe_regs_i (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .reg_req_i ( reg_req_i ),
    .reg_rsp_o ( reg_rsp_o ),
    .pad_cfg_o ( pad_cfg   )
  );

  // Pin side
  padframe_out_mux padframe_out_mux_i (
    .pad_cfg_i  ( pad_cfg    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_dir_i ( gpio_dir_i ),
    .periph_i   ( periph_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

  // Peripheral side
  padframe_in_demux padframe_in_demux_i (
    .pad_cfg_i ( pad_cfg   ),
    .pad_in_i  ( pad_in_i  ),
    .gpio_in_o ( gpio_in_o ),
    .periph_o  ( periph_o  )
  );

endmodule

// ==== padframe_in_demux.sv ====
// Purely combinational, lowest matching pad wins and unassigned inputs idle high
`include "padframe_cfg.svh"

module padframe_in_demux (
  input  padframe_pkg::pad_cfg_array_t pad_cfg_i,
  input  padframe_pkg::pad_vec_t       pad_in_i,
  output padframe_pkg::pad_vec_t       gpio_in_o,
  output padframe_pkg::pad_to_periph_t periph_o
);

  import padframe_pkg::*;

  // Scan from the top so the lowest matching pad is the last one taken
  function automatic logic pick_lowest(
    input pad_cfg_array_t cfg,
    input pad_vec_t       pins,
    input pad_func_t      func,
    input pad_role_t      role
  );
    logic level;
    level = 1'b1;
    for (int p = `PADFRAME_NUM_PADS - 1; p >= 0; p--) begin
      if (cfg[p].func == func && cfg[p].role == role) begin
        level = pins[p];
      end
    end
    return level;
  endfunction

  // GPIO inputs see every pad regardless of function
  assign gpio_in_o = pad_in_i;

  assign periph_o.uart_rx = pick_lowest(
    pad_cfg_i, pad_in_i, `PADFRAME_FUNC_UART, `PADFRAME_ROLE_UART_RX
  );

  assign periph_o.spi_miso = pick_lowest(
    pad_cfg_i, pad_in_i, `PADFRAME_FUNC_SPI, `PADFRAME_ROLE_SPI_MISO
  );

  assign periph_o.i2c_sda_i = pick_lowest(
    pad_cfg_i, pad_in_i, `PADFRAME_FUNC_I2C, `PADFRAME_ROLE_I2C_SDA
  );

  assign periph_o.i2c_scl_i = pick_lowest(
    pad_cfg_i, pad_in_i, `PADFRAME_FUNC_I2C, `PADFRAME_ROLE_I2C_SCL
  );

endmodule

// ==== padframe_out_mux.sv ====
// Purely combinational, undefined roles and input roles leave the pad undriven at level 0
`include "padframe_cfg.svh"

module padframe_out_mux (
  input  padframe_pkg::pad_cfg_array_t pad_cfg_i,
  input  padframe_pkg::pad_vec_t       gpio_out_i,
  input  padframe_pkg::pad_vec_t       gpio_dir_i,
  input  padframe_pkg::periph_to_pad_t periph_i,
  output padframe_pkg::pad_vec_t       pad_out_o,
  output padframe_pkg::pad_vec_t       pad_oe_o
);

  import padframe_pkg::*;

  always_comb begin
    pad_cfg_t cfg;
    cfg = '0;
    for (int p = 0; p < `PADFRAME_NUM_PADS; p++) begin
      cfg          = pad_cfg_i[p];
      pad_out_o[p] = 1'b0;
      pad_oe_o[p]  = 1'b0;
      case (cfg.func)
        `PADFRAME_FUNC_GPIO: begin
          // Role has no meaning here
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_dir_i[p];
        end
        `PADFRAME_FUNC_UART: begin
          if (cfg.role == `PADFRAME_ROLE_UART_TX) begin
            pad_out_o[p] = periph_i.uart_tx;
            pad_oe_o[p]  = 1'b1;
          end
        end
        `PADFRAME_FUNC_SPI: begin
          case (cfg.role)
            `PADFRAME_ROLE_SPI_SCK: begin
              pad_out_o[p] = periph_i.spi_sck;
              pad_oe_o[p]  = 1'b1;
            end
            `PADFRAME_ROLE_SPI_CSN: begin
              pad_out_o[p] = periph_i.spi_csn;
              pad_oe_o[p]  = 1'b1;
            end
            `PADFRAME_ROLE_SPI_MOSI: begin
              pad_out_o[p] = periph_i.spi_mosi;
              pad_oe_o[p]  = 1'b1;
            end
            default: begin
              // MISO is an input
            end
          endcase
        end
        `PADFRAME_FUNC_I2C: begin
          // Open drain style, enable comes from the controller
          case (cfg.role)
            `PADFRAME_ROLE_I2C_SDA: begin
              pad_out_o[p] = periph_i.i2c_sda_o;
              pad_oe_o[p]  = periph_i.i2c_sda_oe;
            end
            `PADFRAME_ROLE_I2C_SCL: begin
              pad_out_o[p] = periph_i.i2c_scl_o;
              pad_oe_o[p]  = periph_i.i2c_scl_oe;
            end
            default: begin
            end
          endcase
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== padframe_regs.sv ====
// Always ready in the request cycle, needs at least two pads, only wdata bits 3:0 are stored
`include "padframe_cfg.svh"

module padframe_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  padframe_pkg::reg_req_t     reg_req_i,
  output padframe_pkg::reg_rsp_t     reg_rsp_o,
  output padframe_pkg::pad_cfg_array_t pad_cfg_o
);

  import padframe_pkg::*;

  localparam int unsigned IdxW = $clog2(`PADFRAME_NUM_PADS);

  reg_addr_t      word_idx;
  logic [IdxW-1:0] pad_idx;
  logic           in_range;
  logic           wr_en;
  pad_cfg_array_t cfg_q;

  // Low address bits drop out of the division
  assign word_idx = reg_req_i.addr / `PADFRAME_REG_STEP;
  assign in_range = (word_idx < `PADFRAME_NUM_PADS);
  assign pad_idx  = word_idx[IdxW-1:0];

  assign wr_en = reg_req_i.valid & reg_req_i.write & in_range;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      cfg_q[pad_idx] <= pad_cfg_t'(reg_req_i.wdata[$bits(pad_cfg_t)-1:0]);
    end
  end

  // Same-cycle response, no back-pressure
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid & ~in_range;
    reg_rsp_o.rdata = '0;
    if (reg_req_i.valid && in_range) begin
      reg_rsp_o.rdata = {{($bits(reg_data_t) - $bits(pad_cfg_t)){1'b0}}, cfg_q[pad_idx]};
    end
  end

  assign pad_cfg_o = cfg_q;

endmodule

// ==== padframe_pkg.sv ====
// Register bus is 32-bit address and data with no strobes and one config entry per pad
`include "padframe_cfg.svh"

package padframe_pkg;

  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  typedef logic [1:0] pad_func_t;
  typedef logic [1:0] pad_role_t;
  typedef logic [`PADFRAME_NUM_PADS-1:0] pad_vec_t;

  // Register layout is {role, func}
  typedef struct packed {
    pad_role_t role;
    pad_func_t func;
  } pad_cfg_t;

  typedef pad_cfg_t [`PADFRAME_NUM_PADS-1:0] pad_cfg_array_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      ready;
    logic      error;
    reg_data_t rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic uart_tx;
    logic spi_sck;
    logic spi_csn;
    logic spi_mosi;
    logic i2c_sda_o;
    logic i2c_sda_oe;
    logic i2c_scl_o;
    logic i2c_scl_oe;
  } periph_to_pad_t;

  typedef struct packed {
    logic uart_rx;
    logic spi_miso;
    logic i2c_sda_i;
    logic i2c_scl_i;
  } pad_to_periph_t;

endpackage

// ==== padframe_cfg.svh ====
// Pad count and register step are fixed at build time and every code is two bits wide
`ifndef PADFRAME_CFG_SVH
`define PADFRAME_CFG_SVH

`define PADFRAME_NUM_PADS 8
`define PADFRAME_REG_STEP 4

`define PADFRAME_FUNC_GPIO 2'd0
`define PADFRAME_FUNC_UART 2'd1
`define PADFRAME_FUNC_SPI  2'd2
`define PADFRAME_FUNC_I2C  2'd3

// Role codes, meaning depends on the selected function
`define PADFRAME_ROLE_UART_TX  2'd0
`define PADFRAME_ROLE_UART_RX  2'd1
`define PADFRAME_ROLE_SPI_SCK  2'd0
`define PADFRAME_ROLE_SPI_CSN  2'd1
`define PADFRAME_ROLE_SPI_MOSI 2'd2
`define PADFRAME_ROLE_SPI_MISO 2'd3
`define PADFRAME_ROLE_I2C_SDA  2'd0
`define PADFRAME_ROLE_I2C_SCL  2'd1

`endif
